// File: rtl/hl2_cmd_pkg.sv
//////////////////////////////
// hl2 command path package
// shared command, decode and response types,
// register addresses for the control domain
//////////////////////////////

`default_nettype none

package hl2_cmd_pkg;

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // register map, everything else reads as zero
  localparam logic [CMD_ADDR_W-1:0] ADDR_GENERAL  = 6'h00;
  localparam logic [CMD_ADDR_W-1:0] ADDR_TX_FREQ  = 6'h01;
  localparam logic [CMD_ADDR_W-1:0] ADDR_RX1_FREQ = 6'h02;

  // one command as it arrives from the network domain
  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    logic [CMD_DATA_W-1:0] data;
    logic                  is_alt;
    logic                  resp_rqst;
  } cmd_word_t;

  // general configuration view, run sits in bit 0
  typedef struct packed {
    logic [CMD_DATA_W-8:0] rsvd;
    logic [3:0]            nr_rx;
    logic                  duplex;
    logic                  ptt_enable;
    logic                  run;
  } gen_cfg_t;

  // same data word, seen as config or as a phase word
  typedef union packed {
    gen_cfg_t              cfg;
    logic [CMD_DATA_W-1:0] freq;
  } cmd_data_u;

  typedef enum logic [1:0] {
    OP_NONE     = 2'd0,
    OP_GEN      = 2'd1,
    OP_TX_FREQ  = 2'd2,
    OP_RX1_FREQ = 2'd3
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e               op;
    logic                  wr_en;
    logic [CMD_ADDR_W-1:0] addr;
    cmd_data_u             data;
    logic                  resp_rqst;
  } dec_cmd_t;

  // control byte first, then the read-back word
  typedef struct packed {
    logic [CMD_ADDR_W-1:0] addr;
    logic                  tx_on;
    logic                  rsvd;
    logic [CMD_DATA_W-1:0] data;
  } resp_t;

endpackage

`default_nettype wire

// File: rtl/cmd_capture.sv
//////////////////////////////
// command capture
// syncs the foreign toggle, turns each change into
// a one-cycle strobe and registers the command word
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmd_capture import hl2_cmd_pkg::*; #(
  parameter int SYNC_DEPTH = 2
) (
  input  wire        clk_ctrl,
  input  wire        rst_n_i,
  input  wire        cmd_cnt_i,
  input  cmd_word_t  cmd_word_i,
  output logic       cmd_stb_o,
  output cmd_word_t  cmd_word_o
);

  logic [SYNC_DEPTH-1:0] sync_q;
  logic                  tog_last_q;
  logic                  tog_edge;
  logic                  cmd_stb_q;
  cmd_word_t             cmd_word_q;

  // any change of the synced toggle is a new command
  assign tog_edge = sync_q[SYNC_DEPTH-1] ^ tog_last_q;

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      // history follows the toggle so release gives no strobe
      sync_q     <= {SYNC_DEPTH{cmd_cnt_i}};
      tog_last_q <= cmd_cnt_i;
      cmd_stb_q  <= 1'b0;
    end else begin
      sync_q     <= {sync_q[SYNC_DEPTH-2:0], cmd_cnt_i};
      tog_last_q <= sync_q[SYNC_DEPTH-1];
      cmd_stb_q  <= tog_edge;
    end
  end

  // sender holds the word steady, so one sample is enough
  always_ff @(posedge clk_ctrl) begin
    if (tog_edge) begin
      cmd_word_q <= cmd_word_i;
    end
  end

  assign cmd_stb_o  = cmd_stb_q;
  assign cmd_word_o = cmd_word_q;

endmodule

`default_nettype wire

// File: rtl/cmd_decode.sv
//////////////////////////////
// command decode
// maps the address to an operation, blocks writes
// from alternate queries and picks the data view
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmd_decode import hl2_cmd_pkg::*; (
  input  wire        clk_ctrl,
  input  wire        rst_n_i,
  input  wire        cmd_stb_i,
  input  cmd_word_t  cmd_word_i,
  output logic       dec_stb_o,
  output dec_cmd_t   dec_cmd_o
);

  cmd_op_e   op_d;
  cmd_data_u data_d;
  logic      dec_stb_q;
  dec_cmd_t  dec_cmd_q;

  always_comb begin
    case (cmd_word_i.addr)
      ADDR_GENERAL:  op_d = OP_GEN;
      ADDR_TX_FREQ:  op_d = OP_TX_FREQ;
      ADDR_RX1_FREQ: op_d = OP_RX1_FREQ;
      default:       op_d = OP_NONE;
    endcase
  end

  // config view drops the reserved field, freq view is raw
  always_comb begin
    data_d.freq = cmd_word_i.data;
    if (op_d == OP_GEN) begin
      data_d.cfg.rsvd = '0;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      dec_stb_q <= 1'b0;
    end else begin
      dec_stb_q <= cmd_stb_i;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (cmd_stb_i) begin
      dec_cmd_q.op        <= op_d;
      dec_cmd_q.wr_en     <= (op_d != OP_NONE) && !cmd_word_i.is_alt;
      dec_cmd_q.addr      <= cmd_word_i.addr;
      dec_cmd_q.data      <= data_d;
      dec_cmd_q.resp_rqst <= cmd_word_i.resp_rqst;
    end
  end

  assign dec_stb_o = dec_stb_q;
  assign dec_cmd_o = dec_cmd_q;

endmodule

`default_nettype wire

// File: rtl/cmd_execute.sv
//////////////////////////////
// command execute
// control register file plus TX keying,
// run/tx LEDs and the PA T/R relay
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cmd_execute import hl2_cmd_pkg::*; (
  input  wire                    clk_ctrl,
  input  wire                    rst_n_i,
  input  wire                    dec_stb_i,
  input  dec_cmd_t               dec_cmd_i,
  input  wire                    ptt_in_i,
  input  wire                    tx_inhibit_i,
  output gen_cfg_t               gen_cfg_o,
  output logic [CMD_DATA_W-1:0]  tx_freq_o,
  output logic [CMD_DATA_W-1:0]  rx1_freq_o,
  output logic                   tx_on_o,
  output logic                   led_run_o,
  output logic                   led_tx_o,
  output logic                   pa_inttr_o
);

  gen_cfg_t              gen_cfg_q;
  logic [CMD_DATA_W-1:0] tx_freq_q;
  logic [CMD_DATA_W-1:0] rx1_freq_q;
  logic                  tx_on_q;
  logic                  do_wr;

  assign do_wr = dec_stb_i && dec_cmd_i.wr_en;

  //////////////////////////////
  // register file
  //////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      gen_cfg_q  <= '0;
      tx_freq_q  <= '0;
      rx1_freq_q <= '0;
    end else if (do_wr) begin
      case (dec_cmd_i.op)
        // reserved bits already zero in the cfg view
        OP_GEN:      gen_cfg_q  <= dec_cmd_i.data.cfg;
        OP_TX_FREQ:  tx_freq_q  <= dec_cmd_i.data.freq;
        OP_RX1_FREQ: rx1_freq_q <= dec_cmd_i.data.freq;
        default:     ;
      endcase
    end
  end

  //////////////////////////////
  // TX keying
  //////////////////////////////

  // re-evaluated every cycle, PTT and inhibit are live levels
  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      tx_on_q <= 1'b0;
    end else begin
      tx_on_q <= gen_cfg_q.run && gen_cfg_q.ptt_enable &&
                 ptt_in_i && !tx_inhibit_i;
    end
  end

  assign gen_cfg_o  = gen_cfg_q;
  assign tx_freq_o  = tx_freq_q;
  assign rx1_freq_o = rx1_freq_q;
  assign tx_on_o    = tx_on_q;

  // front panel and relay
  assign led_run_o  = gen_cfg_q.run;
  assign led_tx_o   = tx_on_q;
  assign pa_inttr_o = tx_on_q;

endmodule

`default_nettype wire

// File: rtl/resp_builder.sv
//////////////////////////////
// response builder
// registers the 40-bit response word and
// pulses valid for one cycle
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module resp_builder import hl2_cmd_pkg::*; (
  input  wire                    clk_ctrl,
  input  wire                    rst_n_i,
  input  wire                    dec_stb_i,
  input  dec_cmd_t               dec_cmd_i,
  input  gen_cfg_t               gen_cfg_i,
  input  wire [CMD_DATA_W-1:0]   tx_freq_i,
  input  wire [CMD_DATA_W-1:0]   rx1_freq_i,
  input  wire                    tx_on_i,
  output resp_t                  resp_o,
  output logic                   resp_valid_o
);

  logic [CMD_DATA_W-1:0] rdbk_d;
  logic                  resp_fire;
  resp_t                 resp_q;
  logic                  resp_valid_q;

  assign resp_fire = dec_stb_i && dec_cmd_i.resp_rqst;

  // read-back after this command, a write shows its own data
  always_comb begin
    case (dec_cmd_i.op)
      OP_GEN:      rdbk_d = dec_cmd_i.wr_en ? dec_cmd_i.data.cfg  : gen_cfg_i;
      OP_TX_FREQ:  rdbk_d = dec_cmd_i.wr_en ? dec_cmd_i.data.freq : tx_freq_i;
      OP_RX1_FREQ: rdbk_d = dec_cmd_i.wr_en ? dec_cmd_i.data.freq : rx1_freq_i;
      default:     rdbk_d = '0;
    endcase
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= resp_fire;
    end
  end

  // tx_on here is the state before this command lands
  always_ff @(posedge clk_ctrl) begin
    if (resp_fire) begin
      resp_q.addr  <= dec_cmd_i.addr;
      resp_q.tx_on <= tx_on_i;
      resp_q.rsvd  <= 1'b0;
      resp_q.data  <= rdbk_d;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

`default_nettype wire

// File: rtl/hl2_cmd_ctrl_top.sv
//////////////////////////////
// hl2 command control top
// downstream command path in the control clock:
// capture, decode, execute and response
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hl2_cmd_ctrl_top import hl2_cmd_pkg::*; #(
  parameter int SYNC_DEPTH = 2
) (
  input  wire                    clk_ctrl,
  input  wire                    rst_n_i,
  input  cmd_word_t              cmd_word_i,
  input  wire                    cmd_cnt_i,
  input  wire                    ptt_in_i,
  input  wire                    tx_inhibit_i,
  output logic [CMD_DATA_W-1:0]  tx_freq_o,
  output logic [CMD_DATA_W-1:0]  rx1_freq_o,
  output logic                   led_run_o,
  output logic                   led_tx_o,
  output logic                   pa_inttr_o,
  output resp_t                  resp_o,
  output logic                   resp_valid_o
);

  logic      cmd_stb;
  cmd_word_t cmd_word;
  logic      dec_stb;
  dec_cmd_t  dec_cmd;
  gen_cfg_t  gen_cfg;
  logic      tx_on;

  cmd_capture #(
    .SYNC_DEPTH (SYNC_DEPTH)
  ) cmd_capture_i (
    .clk_ctrl   (clk_ctrl),
    .rst_n_i    (rst_n_i),
    .cmd_cnt_i  (cmd_cnt_i),
    .cmd_word_i (cmd_word_i),
    .cmd_stb_o  (cmd_stb),
    .cmd_word_o (cmd_word)
  );

  cmd_decode cmd_decode_i (
    .clk_ctrl   (clk_ctrl),
    .rst_n_i    (rst_n_i),
    .cmd_stb_i  (cmd_stb),
    .cmd_word_i (cmd_word),
    .dec_stb_o  (dec_stb),
    .dec_cmd_o  (dec_cmd)
  );

  cmd_execute cmd_execute_i (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .dec_stb_i    (dec_stb),
    .dec_cmd_i    (dec_cmd),
    .ptt_in_i     (ptt_in_i),
    .tx_inhibit_i (tx_inhibit_i),
    .gen_cfg_o    (gen_cfg),
    .tx_freq_o    (tx_freq_o),
    .rx1_freq_o   (rx1_freq_o),
    .tx_on_o      (tx_on),
    .led_run_o    (led_run_o),
    .led_tx_o     (led_tx_o),
    .pa_inttr_o   (pa_inttr_o)
  );

  // sees the same decoded command as execute
  resp_builder resp_builder_i (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .dec_stb_i    (dec_stb),
    .dec_cmd_i    (dec_cmd),
    .gen_cfg_i    (gen_cfg),
    .tx_freq_i    (tx_freq_o),
    .rx1_freq_i   (rx1_freq_o),
    .tx_on_i      (tx_on),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
//////////////////////////////
// testbench clock and reset
// 4 ns control clock, reset low for 8 cycles
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // release away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/tb_hl2_cmd_ctrl.sv
//////////////////////////////
// hl2 command path testbench
// directed tests for register writes, queries,
// TX keying and the response word
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_hl2_cmd_ctrl import hl2_cmd_pkg::*; ();

  localparam int RESP_TIMEOUT = 20;
  localparam int QUIET_CYCLES = 10;
  localparam int KEY_TIMEOUT  = 3;
  // run, ptt_enable, duplex and nr_rx fill bits 6:0
  localparam logic [CMD_DATA_W-1:0] GEN_USED_MASK = 32'h0000_007f;
  localparam logic [CMD_ADDR_W-1:0] ADDR_UNUSED   = 6'h2a;

  // level outputs of the DUT, compared as one group
  typedef struct packed {
    logic [CMD_DATA_W-1:0] tx_freq;
    logic [CMD_DATA_W-1:0] rx1_freq;
    logic                  led_run;
    logic                  led_tx;
    logic                  pa_inttr;
  } lvl_out_t;

  logic                  clk_ctrl;
  logic                  rst_n;
  cmd_word_t             cmd_word;
  logic                  cmd_cnt;
  logic                  ptt_in;
  logic                  tx_inhibit;
  logic [CMD_DATA_W-1:0] tx_freq;
  logic [CMD_DATA_W-1:0] rx1_freq;
  logic                  led_run;
  logic                  led_tx;
  logic                  pa_inttr;
  resp_t                 resp;
  logic                  resp_valid;
  lvl_out_t              exp_lvl;
  int                    err_cnt;
  int                    timeout_cnt;

  tb_clk_gen tb_clk_gen_i (
    .clk_o   (clk_ctrl),
    .rst_n_o (rst_n)
  );

  hl2_cmd_ctrl_top #(
    .SYNC_DEPTH (2)
  ) hl2_cmd_ctrl_top_i (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n),
    .cmd_word_i   (cmd_word),
    .cmd_cnt_i    (cmd_cnt),
    .ptt_in_i     (ptt_in),
    .tx_inhibit_i (tx_inhibit),
    .tx_freq_o    (tx_freq),
    .rx1_freq_o   (rx1_freq),
    .led_run_o    (led_run),
    .led_tx_o     (led_tx),
    .pa_inttr_o   (pa_inttr),
    .resp_o       (resp),
    .resp_valid_o (resp_valid)
  );

  //////////////////////////////
  // compare helpers
  //////////////////////////////

  function automatic resp_t make_resp(input logic [CMD_ADDR_W-1:0] addr, input logic tx_on,
                                      input logic [CMD_DATA_W-1:0] data);
    resp_t r;
    r.addr  = addr;
    r.tx_on = tx_on;
    r.rsvd  = 1'b0;
    r.data  = data;
    return r;
  endfunction

  task automatic check_resp(input string tag, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      $display("Error: resp_o got %h exp %h (%s)", got, exp, tag);
      err_cnt++;
    end
  endtask

  task automatic check_cfg_out(input string tag, input lvl_out_t exp);
    lvl_out_t got;
    got = '{tx_freq: tx_freq, rx1_freq: rx1_freq, led_run: led_run,
            led_tx: led_tx, pa_inttr: pa_inttr};
    if (got.tx_freq !== exp.tx_freq) begin
      $display("Error: tx_freq_o got %h exp %h (%s)", got.tx_freq, exp.tx_freq, tag);
      err_cnt++;
    end
    if (got.rx1_freq !== exp.rx1_freq) begin
      $display("Error: rx1_freq_o got %h exp %h (%s)", got.rx1_freq, exp.rx1_freq, tag);
      err_cnt++;
    end
    if (got.led_run !== exp.led_run) begin
      $display("Error: led_run_o got %h exp %h (%s)", got.led_run, exp.led_run, tag);
      err_cnt++;
    end
    if (got.led_tx !== exp.led_tx) begin
      $display("Error: led_tx_o got %h exp %h (%s)", got.led_tx, exp.led_tx, tag);
      err_cnt++;
    end
    if (got.pa_inttr !== exp.pa_inttr) begin
      $display("Error: pa_inttr_o got %h exp %h (%s)", got.pa_inttr, exp.pa_inttr, tag);
      err_cnt++;
    end
  endtask

  //////////////////////////////
  // drivers and waits
  //////////////////////////////

  // idle first so commands stay well apart
  task automatic send_cmd(input logic [CMD_ADDR_W-1:0] addr, input logic [CMD_DATA_W-1:0] data,
                          input logic is_alt, input logic rqst);
    repeat (4) @(negedge clk_ctrl);
    cmd_word.addr      = addr;
    cmd_word.data      = data;
    cmd_word.is_alt    = is_alt;
    cmd_word.resp_rqst = rqst;
    cmd_cnt            = ~cmd_cnt;
  endtask

  task automatic wait_resp(input string tag, output resp_t got, output bit seen);
    int n;
    seen = 1'b0;
    got  = '0;
    n    = 0;
    while (!seen && n < RESP_TIMEOUT) begin
      @(negedge clk_ctrl);
      if (resp_valid) begin
        seen = 1'b1;
        got  = resp;
      end
      n++;
    end
    if (!seen) begin
      $display("Timeout: no response pulse within %0d cycles (%s)", RESP_TIMEOUT, tag);
      timeout_cnt++;
    end else begin
      // valid must be a single-cycle pulse
      @(negedge clk_ctrl);
      if (resp_valid !== 1'b0) begin
        $display("Error: resp_valid_o got %h exp %h (%s)", resp_valid, 1'b0, tag);
        err_cnt++;
      end
    end
  endtask

  task automatic query(input string tag, input logic [CMD_ADDR_W-1:0] addr,
                       input logic [CMD_DATA_W-1:0] data, input logic is_alt,
                       input resp_t exp);
    resp_t got;
    bit    seen;
    send_cmd(addr, data, is_alt, 1'b1);
    wait_resp(tag, got, seen);
    if (seen) begin
      check_resp(tag, got, exp);
    end
  endtask

  task automatic expect_no_resp(input string tag);
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk_ctrl);
      if (resp_valid) begin
        $display("Unexpected response pulse %0d cycles into the quiet window (%s)", i, tag);
        err_cnt++;
      end
    end
  endtask

  task automatic wait_led_tx(input logic val, input string tag);
    int n;
    n = 0;
    while (led_tx !== val && n < KEY_TIMEOUT) begin
      @(negedge clk_ctrl);
      n++;
    end
    if (led_tx !== val) begin
      $display("Timeout: led_tx_o did not reach %0b within %0d cycles (%s)",
               val, KEY_TIMEOUT, tag);
      timeout_cnt++;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(negedge clk_ctrl);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeout_cnt++;
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset_state();
    check_cfg_out("reset state", '0);
    expect_no_resp("after reset");
  endtask

  task automatic test_freq_writes();
    logic [CMD_DATA_W-1:0] w;
    w = $urandom();
    query("tx freq write", ADDR_TX_FREQ, w, 1'b0, make_resp(ADDR_TX_FREQ, 1'b0, w));
    exp_lvl.tx_freq = w;
    w = $urandom();
    query("rx1 freq write", ADDR_RX1_FREQ, w, 1'b0, make_resp(ADDR_RX1_FREQ, 1'b0, w));
    exp_lvl.rx1_freq = w;
    repeat (2) @(negedge clk_ctrl);
    check_cfg_out("freq outputs", exp_lvl);
  endtask

  task automatic test_gen_cfg();
    logic [CMD_DATA_W-1:0] w;
    gen_cfg_t              cfg;
    w   = $urandom();
    cfg = gen_cfg_t'(w);
    query("general write", ADDR_GENERAL, w, 1'b0,
          make_resp(ADDR_GENERAL, 1'b0, w & GEN_USED_MASK));
    exp_lvl.led_run = cfg.run;
    repeat (2) @(negedge clk_ctrl);
    check_cfg_out("general write", exp_lvl);
  endtask

  task automatic test_alt_query();
    query("tx freq query", ADDR_TX_FREQ, $urandom(), 1'b1,
          make_resp(ADDR_TX_FREQ, 1'b0, exp_lvl.tx_freq));
    query("unknown addr", ADDR_UNUSED, $urandom(), 1'b0,
          make_resp(ADDR_UNUSED, 1'b0, '0));
    repeat (2) @(negedge clk_ctrl);
    check_cfg_out("after queries", exp_lvl);
  endtask

  task automatic test_tx_keying();
    logic [CMD_DATA_W-1:0] w;
    // run and ptt_enable forced on
    w = $urandom() | 32'h0000_0003;
    query("keying setup", ADDR_GENERAL, w, 1'b0,
          make_resp(ADDR_GENERAL, 1'b0, w & GEN_USED_MASK));
    exp_lvl.led_run = 1'b1;
    @(negedge clk_ctrl);
    ptt_in = 1'b1;
    wait_led_tx(1'b1, "ptt on");
    exp_lvl.led_tx   = 1'b1;
    exp_lvl.pa_inttr = 1'b1;
    check_cfg_out("ptt on", exp_lvl);
    query("tx on query", ADDR_GENERAL, $urandom(), 1'b1,
          make_resp(ADDR_GENERAL, 1'b1, w & GEN_USED_MASK));
    @(negedge clk_ctrl);
    tx_inhibit = 1'b1;
    wait_led_tx(1'b0, "inhibit");
    exp_lvl.led_tx   = 1'b0;
    exp_lvl.pa_inttr = 1'b0;
    check_cfg_out("inhibit", exp_lvl);
    query("inhibit query", ADDR_GENERAL, $urandom(), 1'b1,
          make_resp(ADDR_GENERAL, 1'b0, w & GEN_USED_MASK));
    ptt_in     = 1'b0;
    tx_inhibit = 1'b0;
  endtask

  task automatic test_no_resp();
    logic [CMD_DATA_W-1:0] w;
    w = $urandom();
    send_cmd(ADDR_RX1_FREQ, w, 1'b0, 1'b0);
    expect_no_resp("write without request");
    exp_lvl.rx1_freq = w;
    check_cfg_out("write without request", exp_lvl);
  endtask

  initial begin
    void'($urandom(32'h7830c955));
    cmd_word    = '0;
    cmd_cnt     = 1'b0;
    ptt_in      = 1'b0;
    tx_inhibit  = 1'b0;
    exp_lvl     = '0;
    err_cnt     = 0;
    timeout_cnt = 0;
    wait_reset_release();
    test_reset_state();
    test_freq_writes();
    test_gen_cfg();
    test_alt_query();
    test_tx_keying();
    test_no_resp();
    repeat (4) @(negedge clk_ctrl);
    $display("errors: %0d check, %0d timeout", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
rtl/hl2_cmd_pkg.sv
rtl/cmd_capture.sv
rtl/cmd_decode.sv
rtl/cmd_execute.sv
rtl/resp_builder.sv
rtl/hl2_cmd_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_hl2_cmd_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the command path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_hl2_cmd_ctrl \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
